/* rtl/volley_pkg.sv */
package volley_pkg;

   // ball coordinate and score widths.
   localparam int coord_w = 12;
   localparam int score_w = 4;

   // court geometry in screen pixels, y grows downward.
   localparam logic [coord_w-1:0] net_left  = 12'd500;
   localparam logic [coord_w-1:0] net_right = 12'd523;
   localparam logic [coord_w-1:0] ground_y  = 12'd750;

   // rule values loaded at reset.
   localparam logic [score_w-1:0] win_score_default   = 4'd15;
   localparam logic [2:0]         touch_limit_default = 3'd4;
   localparam logic [7:0]         holdoff_default     = 8'd200;

   typedef enum logic [1:0] {
      st_serve,
      st_rally,
      st_point,
      st_over
   } judge_state_t;

   // where the ball came down.
   typedef enum logic [1:0] {
      side_left,
      side_net,
      side_right
   } side_t;

endpackage

/* rtl/rule_regs.sv */
`timescale 1ns/1ps

module rule_regs (
   input  logic                           clk,
   input  logic                           rst_d,
   input  logic                           cfg_write,
   input  logic [1:0]                     cfg_addr,
   input  logic [7:0]                     cfg_data,
   output logic [volley_pkg::score_w-1:0] win_score,
   output logic [2:0]                     touch_limit,
   output logic [7:0]                     holdoff
);
   import volley_pkg::*;

   localparam logic [1:0] addr_win_score   = 2'd0;
   localparam logic [1:0] addr_touch_limit = 2'd1;
   localparam logic [1:0] addr_holdoff     = 2'd2;

   always_ff @(posedge clk) begin
      if (rst_d) begin
         win_score   <= win_score_default;
         touch_limit <= touch_limit_default;
         holdoff     <= holdoff_default;
      end else if (cfg_write) begin
         // narrow fields keep the low bits of the data byte.
         case (cfg_addr)
            addr_win_score: begin
               win_score <= cfg_data[score_w-1:0];
            end
            addr_touch_limit: begin
               touch_limit <= cfg_data[2:0];
            end
            addr_holdoff: begin
               holdoff <= cfg_data;
            end
            default: begin
               // address 3 is unused.
            end
         endcase
      end
   end

endmodule

/* rtl/touch_filter.sv */
`timescale 1ns/1ps

module touch_filter (
   input  logic       clk,
   input  logic       rst_d,
   input  logic       hit_p1,
   input  logic       hit_p2,
   input  logic [7:0] holdoff,
   output logic       touch_p1,
   output logic       touch_p2
);

   logic       hit_p1_q;
   logic       hit_p2_q;
   logic       rise_p1;
   logic       rise_p2;
   logic       idle;
   logic [7:0] timer;

   assign rise_p1 = hit_p1 & ~hit_p1_q;
   assign rise_p2 = hit_p2 & ~hit_p2_q;
   assign idle    = (timer == 8'd0);

   always_ff @(posedge clk) begin
      if (rst_d) begin
         hit_p1_q <= 1'b0;
         hit_p2_q <= 1'b0;
         touch_p1 <= 1'b0;
         touch_p2 <= 1'b0;
         timer    <= 8'd0;
      end else begin
         hit_p1_q <= hit_p1;
         hit_p2_q <= hit_p2;
         // player 1 wins a tie.
         touch_p1 <= idle & rise_p1;
         touch_p2 <= idle & rise_p2 & ~rise_p1;
         // one timer covers both players.
         if (idle && (rise_p1 || rise_p2)) begin
            timer <= holdoff;
         end else if (!idle) begin
            timer <= timer - 8'd1;
         end
      end
   end

endmodule

/* rtl/landing_detect.sv */
`timescale 1ns/1ps

module landing_detect (
   input  logic                           clk,
   input  logic                           rst_d,
   input  logic [volley_pkg::coord_w-1:0] gnd_y,
   input  logic [volley_pkg::coord_w-1:0] ball_x,
   output logic                           land,
   output volley_pkg::side_t              land_side
);
   import volley_pkg::*;

   logic  at_ground;
   logic  armed;
   side_t side_now;

   assign at_ground = (gnd_y >= ground_y);

   always_comb begin
      if (ball_x <= net_left) begin
         side_now = side_left;
      end else if (ball_x >= net_right) begin
         side_now = side_right;
      end else begin
         side_now = side_net;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_d) begin
         land  <= 1'b0;
         armed <= 1'b1;
      end else begin
         land  <= at_ground & armed;
         // the ball has to leave the ground before the next landing.
         armed <= ~at_ground;
      end
   end

   always_ff @(posedge clk) begin
      if (at_ground && armed) begin
         land_side <= side_now;
      end
   end

endmodule

/* rtl/rally_judge.sv */
`timescale 1ns/1ps

module rally_judge (
   input  logic                           clk,
   input  logic                           rst_d,
   input  logic                           touch_p1,
   input  logic                           touch_p2,
   input  logic                           land,
   input  volley_pkg::side_t              land_side,
   input  logic [volley_pkg::score_w-1:0] win_score,
   input  logic [2:0]                     touch_limit,
   output logic [volley_pkg::score_w-1:0] score_p1,
   output logic [volley_pkg::score_w-1:0] score_p2,
   output logic                           point_winner,
   output logic                           point_strobe,
   output logic                           touch_fault,
   output logic                           game_over
);
   import volley_pkg::*;

   judge_state_t       state;
   judge_state_t       state_nxt;
   logic [2:0]         count_p1;
   logic [2:0]         count_p2;
   logic [2:0]         count_p1_nxt;
   logic [2:0]         count_p2_nxt;
   logic               last_p2;
   logic               last_p2_nxt;
   logic               winner;
   logic               winner_nxt;
   logic               fault_nxt;
   logic [score_w-1:0] score_p1_inc;
   logic [score_w-1:0] score_p2_inc;
   logic               reach_win;

   assign score_p1_inc = score_p1 + 1'b1;
   assign score_p2_inc = score_p2 + 1'b1;
   assign reach_win    = winner ? (score_p2_inc == win_score) : (score_p1_inc == win_score);

   always_comb begin
      state_nxt    = state;
      count_p1_nxt = count_p1;
      count_p2_nxt = count_p2;
      last_p2_nxt  = last_p2;
      winner_nxt   = winner;
      fault_nxt    = touch_fault;
      case (state)
         st_serve, st_rally: begin
            if (state == st_rally && land) begin
               state_nxt = st_point;
               case (land_side)
                  side_left:  winner_nxt = 1'b1;
                  side_right: winner_nxt = 1'b0;
                  default:    winner_nxt = ~last_p2;
               endcase
            end else if (touch_p1) begin
               state_nxt    = st_rally;
               count_p1_nxt = count_p1 + 3'd1;
               count_p2_nxt = 3'd0;
               last_p2_nxt  = 1'b0;
               if (count_p1 + 3'd1 == touch_limit) begin
                  state_nxt  = st_point;
                  winner_nxt = 1'b1;
                  fault_nxt  = 1'b1;
               end
            end else if (touch_p2) begin
               state_nxt    = st_rally;
               count_p2_nxt = count_p2 + 3'd1;
               count_p1_nxt = 3'd0;
               last_p2_nxt  = 1'b1;
               if (count_p2 + 3'd1 == touch_limit) begin
                  state_nxt  = st_point;
                  winner_nxt = 1'b0;
                  fault_nxt  = 1'b1;
               end
            end
         end
         st_point: begin
            state_nxt    = reach_win ? st_over : st_serve;
            count_p1_nxt = 3'd0;
            count_p2_nxt = 3'd0;
            fault_nxt    = 1'b0;
         end
         default: begin
            // game over holds until reset.
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst_d) begin
         state        <= st_serve;
         count_p1     <= 3'd0;
         count_p2     <= 3'd0;
         last_p2      <= 1'b0;
         winner       <= 1'b0;
         touch_fault  <= 1'b0;
         score_p1     <= '0;
         score_p2     <= '0;
         point_winner <= 1'b0;
         point_strobe <= 1'b0;
         game_over    <= 1'b0;
      end else begin
         state        <= state_nxt;
         count_p1     <= count_p1_nxt;
         count_p2     <= count_p2_nxt;
         last_p2      <= last_p2_nxt;
         winner       <= winner_nxt;
         touch_fault  <= fault_nxt;
         point_strobe <= (state == st_point);
         // the score moves one cycle after the decision.
         if (state == st_point) begin
            point_winner <= winner;
            if (winner) begin
               score_p2 <= score_p2_inc;
            end else begin
               score_p1 <= score_p1_inc;
            end
            if (reach_win) begin
               game_over <= 1'b1;
            end
         end
      end
   end

endmodule

/* rtl/volley_referee_top.sv */
`timescale 1ns/1ps

module volley_referee_top (
   input  logic                           clk,
   input  logic                           rst_d,
   input  logic [volley_pkg::coord_w-1:0] gnd_y,
   input  logic [volley_pkg::coord_w-1:0] ball_x,
   input  logic                           hit_p1,
   input  logic                           hit_p2,
   input  logic                           cfg_write,
   input  logic [1:0]                     cfg_addr,
   input  logic [7:0]                     cfg_data,
   output logic [volley_pkg::score_w-1:0] score_p1,
   output logic [volley_pkg::score_w-1:0] score_p2,
   output logic                           point_winner,
   output logic                           point_strobe,
   output logic                           touch_fault,
   output logic                           game_over
);
   import volley_pkg::*;

   logic [score_w-1:0] win_score;
   logic [2:0]         touch_limit;
   logic [7:0]         holdoff;
   logic               touch_p1;
   logic               touch_p2;
   logic               land;
   side_t              land_side;

   rule_regs regs0 (
      .clk         (clk),
      .rst_d       (rst_d),
      .cfg_write   (cfg_write),
      .cfg_addr    (cfg_addr),
      .cfg_data    (cfg_data),
      .win_score   (win_score),
      .touch_limit (touch_limit),
      .holdoff     (holdoff)
   );

   touch_filter filt0 (
      .clk      (clk),
      .rst_d    (rst_d),
      .hit_p1   (hit_p1),
      .hit_p2   (hit_p2),
      .holdoff  (holdoff),
      .touch_p1 (touch_p1),
      .touch_p2 (touch_p2)
   );

   landing_detect land0 (
      .clk       (clk),
      .rst_d     (rst_d),
      .gnd_y     (gnd_y),
      .ball_x    (ball_x),
      .land      (land),
      .land_side (land_side)
   );

   rally_judge judge0 (
      .clk          (clk),
      .rst_d        (rst_d),
      .touch_p1     (touch_p1),
      .touch_p2     (touch_p2),
      .land         (land),
      .land_side    (land_side),
      .win_score    (win_score),
      .touch_limit  (touch_limit),
      .score_p1     (score_p1),
      .score_p2     (score_p2),
      .point_winner (point_winner),
      .point_strobe (point_strobe),
      .touch_fault  (touch_fault),
      .game_over    (game_over)
   );

endmodule

/* verif/volley_referee_asserts.sv */
`timescale 1ns/1ps

module volley_referee_asserts (
   input logic                           clk,
   input logic                           rst_d,
   input logic [volley_pkg::score_w-1:0] score_p1,
   input logic [volley_pkg::score_w-1:0] score_p2,
   input logic                           point_strobe,
   input logic                           game_over
);

   int fail_count = 0;

   strobe_one_cycle: assert property (@(posedge clk) disable iff (rst_d)
      point_strobe |=> !point_strobe)
   else begin
      fail_count++;
      $error("point_strobe stayed high for more than one cycle");
   end

   // a score moves only with the strobe, and by one.
   p1_score_step: assert property (@(posedge clk) disable iff (rst_d)
      !$stable(score_p1) |-> point_strobe && (score_p1 == $past(score_p1) + 4'd1))
   else begin
      fail_count++;
      $error("score_p1 changed without a point or by more than one");
   end

   p2_score_step: assert property (@(posedge clk) disable iff (rst_d)
      !$stable(score_p2) |-> point_strobe && (score_p2 == $past(score_p2) + 4'd1))
   else begin
      fail_count++;
      $error("score_p2 changed without a point or by more than one");
   end

   game_over_sticky: assert property (@(posedge clk) disable iff (rst_d)
      game_over |=> game_over)
   else begin
      fail_count++;
      $error("game_over fell before reset");
   end

   no_score_after_over: assert property (@(posedge clk) disable iff (rst_d)
      game_over |=> $stable(score_p1) && $stable(score_p2) && !point_strobe)
   else begin
      fail_count++;
      $error("a point was scored after game over");
   end

endmodule

bind volley_referee_top volley_referee_asserts asserts0 (
   .clk          (clk),
   .rst_d        (rst_d),
   .score_p1     (score_p1),
   .score_p2     (score_p2),
   .point_strobe (point_strobe),
   .game_over    (game_over)
);

/* verif/tb_volley_referee.sv */
`timescale 1ns/1ps

module tb_volley_referee;
   import volley_pkg::*;

   logic               clk = 1'b0;
   logic               rst_d = 1'b1;
   logic [coord_w-1:0] gnd_y = 12'd100;
   logic [coord_w-1:0] ball_x = '0;
   logic               hit_p1 = 1'b0;
   logic               hit_p2 = 1'b0;
   logic               cfg_write = 1'b0;
   logic [1:0]         cfg_addr = 2'd0;
   logic [7:0]         cfg_data = 8'd0;
   logic [score_w-1:0] score_p1;
   logic [score_w-1:0] score_p2;
   logic               point_winner;
   logic               point_strobe;
   logic               touch_fault;
   logic               game_over;
   logic [score_w-1:0] exp_p1 = '0;
   logic [score_w-1:0] exp_p2 = '0;
   int                 strobes = 0;
   int                 faults = 0;
   int                 errors = 0;
   int                 mark = 0;
   int                 passed = 0;

   volley_referee_top dut0 (.*);

   always #50 clk = ~clk;

   // pulses are counted at the edge so a one-cycle pulse is never missed.
   always @(posedge clk) begin
      if (point_strobe) begin
         strobes++;
      end
      if (touch_fault) begin
         faults++;
      end
   end

   task automatic step(input int n);
      repeat (n) begin
         @(posedge clk);
         #5;
      end
   endtask

   task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
      assert (act === exp) else begin
         $display("FAIL %s expected %h got %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic write_rule(input logic [1:0] addr, input logic [7:0] data);
      cfg_write = 1'b1;
      cfg_addr  = addr;
      cfg_data  = data;
      step(1);
      cfg_write = 1'b0;
   endtask

   // a double contact rises twice inside the 3-cycle hold-off.
   task automatic touch(input logic p2, input logic twice);
      repeat (twice ? 2 : 1) begin
         hit_p1 = ~p2;
         hit_p2 = p2;
         step(twice ? 1 : 2);
         hit_p1 = 1'b0;
         hit_p2 = 1'b0;
         step(1);
      end
      step(4);
   endtask

   // optional landing at x, then the strobe and the score model.
   task automatic score_point(input int base, input logic land, input logic [coord_w-1:0] x,
                              input logic p2_wins);
      int cycles;
      if (land) begin
         ball_x = x;
         gnd_y  = ground_y;
      end
      step(1);
      gnd_y  = 12'd100;
      cycles = 0;
      while (strobes == base && cycles < 50) begin
         step(1);
         cycles++;
      end
      if (strobes == base) begin
         $display("point strobe never came");
         errors++;
      end
      // the strobe shows 3 edges after the edge that sampled the landing.
      if (land) begin
         check("point_strobe latency", 16'd3, cycles[15:0]);
      end
      if (p2_wins) begin
         exp_p2++;
      end else begin
         exp_p1++;
      end
      check("score_p1,score_p2,point_winner", {exp_p1, exp_p2, p2_wins},
            {score_p1, score_p2, point_winner});
   endtask

   task automatic end_test(input string name);
      if (errors + dut0.asserts0.fail_count == mark) begin
         passed++;
         $display("test %s: pass", name);
      end else begin
         $display("test %s: fail", name);
      end
      mark = errors + dut0.asserts0.fail_count;
   endtask

   initial begin
      int base;
      int fbase;
      void'($urandom(32'h11ab));
      step(8);
      rst_d = 1'b0;

      check("score_p1,score_p2,point_winner,point_strobe,touch_fault,game_over", 16'd0,
            {score_p1, score_p2, point_winner, point_strobe, touch_fault, game_over});
      write_rule(2'd2, 8'd3);
      write_rule(2'd0, 8'd3);
      // the touch limit default is already 4, so move it away first.
      write_rule(2'd1, 8'd5);
      check("win_score,touch_limit,holdoff", {4'd3, 3'd5, 8'd3},
            {dut0.win_score, dut0.touch_limit, dut0.holdoff});
      write_rule(2'd1, 8'd4);
      check("touch_limit", 16'd4, dut0.touch_limit);
      end_test("reset and rule writes");

      touch(1'b0, 1'b0);
      score_point(strobes, 1'b1, 12'($urandom % 501), 1'b1);
      touch(1'b1, 1'b0);
      score_point(strobes, 1'b1, 12'(523 + $urandom % 1000), 1'b0);
      end_test("left and right landings");

      base  = strobes;
      fbase = faults;
      repeat (4) begin
         touch(1'b0, 1'b0);
      end
      check("touch_fault", 16'd1, 16'(faults > fbase));
      score_point(base, 1'b0, '0, 1'b1);
      fbase = faults;
      for (int i = 0; i < 6; i++) begin
         touch(i[0], 1'b0);
      end
      check("touch_fault", 16'd0, 16'(faults > fbase));
      end_test("touch limit fault");

      // player 2 touched last, so the net landing goes to player 1.
      score_point(strobes, 1'b1, 12'(501 + $urandom % 22), 1'b0);
      end_test("net landing");

      fbase = faults;
      repeat (3) begin
         touch(1'b0, 1'b1);
      end
      touch(1'b1, 1'b0);
      check("touch_fault", 16'd0, 16'(faults > fbase));
      end_test("hold-off merges double contacts");

      score_point(strobes, 1'b1, 12'(523 + $urandom % 1000), 1'b0);
      check("game_over", 16'd1, game_over);
      base = strobes;
      touch(1'b0, 1'b0);
      touch(1'b1, 1'b0);
      ball_x = 12'($urandom % 501);
      gnd_y  = ground_y;
      step(2);
      gnd_y  = 12'd100;
      step(4);
      check("point_strobe count", base[15:0], strobes[15:0]);
      check("score_p1,score_p2,game_over", {exp_p1, exp_p2, 1'b1},
            {score_p1, score_p2, game_over});
      end_test("game over");

      mark = errors + dut0.asserts0.fail_count;
      $display("tests passed %0d of 6, errors %0d", passed, mark);
      if (mark == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

/* project.f */
rtl/volley_pkg.sv
rtl/rule_regs.sv
rtl/touch_filter.sv
rtl/landing_detect.sv
rtl/rally_judge.sv
rtl/volley_referee_top.sv
verif/volley_referee_asserts.sv
verif/tb_volley_referee.sv

/* Bender.yml */
package:
  name: volley_referee

sources:
  - rtl/volley_pkg.sv
  - rtl/rule_regs.sv
  - rtl/touch_filter.sv
  - rtl/landing_detect.sv
  - rtl/rally_judge.sv
  - rtl/volley_referee_top.sv
  - target: simulation
    files:
      - verif/volley_referee_asserts.sv
      - verif/tb_volley_referee.sv
